/* vlog.f */
hw/cpuPkg.sv
hw/controller.sv
hw/alu.sv
hw/registerFile.sv
hw/programCounter.sv
hw/dataMemory.sv
hw/processor.sv
bench/processorModel.sv
bench/processorTb.sv

/* bench/processorTb.sv */
`default_nettype none

module processorTb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int resetCycles = 10;
	localparam int runCycles = 3000; // checked cycles after reset
	localparam int timeoutCycles = runCycles + resetCycles + 100;
	localparam int prologueCalls = 10; // nests deeper than the return stack

	logic clock;
	logic rst;
	logic [cpuPkg::instrWidth-1:0] instruction;
	logic [cpuPkg::pcWidth-1:0] pc;
	logic regWrite;
	logic [cpuPkg::regAddrWidth-1:0] regAddr;
	logic [cpuPkg::dataWidth-1:0] regData;
	logic memWrite;
	logic [cpuPkg::memAddrWidth-1:0] memAddr;
	logic [cpuPkg::dataWidth-1:0] memData;
	logic [cpuPkg::instrWidth-1:0] imem [1 << cpuPkg::pcWidth];
	int cycleCount;
	int checkedCycles;

	processor UUT (
		.clock(clock),
		.rst(rst),
		.instruction(instruction),
		.pc(pc),
		.regWrite(regWrite),
		.regAddr(regAddr),
		.regData(regData),
		.memWrite(memWrite),
		.memAddr(memAddr),
		.memData(memData)
	);

	processorModel model ();

	always #2 clock = ~clock;

	task automatic failRun(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic checkPc(input logic [cpuPkg::pcWidth-1:0] actual,
		input logic [cpuPkg::pcWidth-1:0] expected);
		if (actual !== expected)
			failRun($sformatf("[FAIL] %0t pc: expected %h, got %h", $time, expected, actual));
	endtask

	// address and data only matter while the write is enabled
	task automatic checkRegWrite(input logic en, input logic [cpuPkg::regAddrWidth-1:0] addr,
		input logic [cpuPkg::dataWidth-1:0] data, input logic expEn,
		input logic [cpuPkg::regAddrWidth-1:0] expAddr,
		input logic [cpuPkg::dataWidth-1:0] expData);
		if (en !== expEn)
			failRun($sformatf("[FAIL] %0t regWrite: expected %b, got %b", $time, expEn, en));
		else if (expEn && addr !== expAddr)
			failRun($sformatf("[FAIL] %0t regAddr: expected %h, got %h", $time, expAddr, addr));
		else if (expEn && data !== expData)
			failRun($sformatf("[FAIL] %0t regData: expected %h, got %h", $time, expData, data));
	endtask

	task automatic checkStore(input logic en, input logic [cpuPkg::memAddrWidth-1:0] addr,
		input logic [cpuPkg::dataWidth-1:0] data, input logic expEn,
		input logic [cpuPkg::memAddrWidth-1:0] expAddr,
		input logic [cpuPkg::dataWidth-1:0] expData);
		if (en !== expEn)
			failRun($sformatf("[FAIL] %0t memWrite: expected %b, got %b", $time, expEn, en));
		else if (expEn && addr !== expAddr)
			failRun($sformatf("[FAIL] %0t memAddr: expected %h, got %h", $time, expAddr, addr));
		else if (expEn && data !== expData)
			failRun($sformatf("[FAIL] %0t memData: expected %h, got %h", $time, expData, data));
	endtask

	// about one word in eight moves the pc, the rest compute, shift, load or store
	function automatic logic [cpuPkg::instrWidth-1:0] randomWord(input int addr);
		logic [cpuPkg::instrWidth-1:0] w;
		logic [cpuPkg::pcWidth-1:0] target;
		w = cpuPkg::instrWidth'($urandom);
		target = cpuPkg::pcWidth'($urandom);
		if (target == cpuPkg::pcWidth'(addr))
			target = target + 1'b1; // a transfer onto itself would spin forever
		if ($urandom % 8 == 0) begin
			case ($urandom % 4)
				0: begin
					w[18:16] = 3'b101;
					if (w[7:0] == 8'h00)
						w[7:0] = 8'h01; // same reason as above
				end
				1: begin
					w[18:14] = 5'b11100;
					w[11:0] = target;
				end
				2: begin
					w[18:14] = 5'b11101;
					w[11:0] = target;
				end
				default: w[18:13] = 6'b111100;
			endcase
		end else begin
			case ($urandom % 4)
				0: w[18:17] = 2'b00;
				1: w[18:17] = 2'b01;
				2: w[18:16] = 3'b110;
				default: begin
					w[18:16] = 3'b100;
					w[15] = 1'b0; // load or store only
					w[7:4] = 4'h0; // small offsets so loads hit earlier stores
				end
			endcase
		end
		return w;
	endfunction

	initial begin
		void'($urandom(39532));
		clock = 1'b0;
		rst = 1'b1;
		instruction = cpuPkg::nopWord;
		cycleCount = 0;
		checkedCycles = 0;
		// chain of calls so every stack entry holds an address before a return can run
		for (int i = 0; i < prologueCalls; i++)
			imem[i] = {5'b11101, 2'b00, cpuPkg::pcWidth'(i + 1)};
		for (int i = prologueCalls; i < (1 << cpuPkg::pcWidth); i++)
			imem[i] = randomWord(i);
		repeat (resetCycles) @(posedge clock);
		rst <= 1'b0;
		wait (checkedCycles == runCycles);
		$display("Simulation passed");
		$finish;
	end

	// the word at the previous pc arrives one cycle after it was addressed
	always @(posedge clock) begin
		instruction <= rst ? cpuPkg::nopWord : imem[pc];
	end

	always @(posedge clock) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= timeoutCycles)
			failRun("timeout: the run did not reach its end within the cycle limit");
	end

	// outputs are settled by the falling edge, the model steps right after the checks
	always @(negedge clock) begin
		if (rst) begin
			model.resetState();
		end else begin
			model.evaluate();
			checkPc(pc, model.fetchPc);
			checkRegWrite(regWrite, regAddr, regData, model.expRegWrite, model.expRegAddr,
				model.expRegData);
			checkStore(memWrite, memAddr, memData, model.expMemWrite, model.expMemAddr,
				model.expMemData);
			model.commit(imem[model.fetchPc]);
			checkedCycles = checkedCycles + 1;
		end
	end

endmodule

`default_nettype wire

/* bench/processorModel.sv */
`default_nettype none

// instruction-level reference that steps once per clock, same two-stage timing as the DUT
module processorModel;
	timeunit 1ns;
	timeprecision 1ps;

	logic [cpuPkg::pcWidth-1:0] fetchPc; // address the DUT should show on pc this cycle
	logic [cpuPkg::pcWidth-1:0] exPc;
	logic [cpuPkg::instrWidth-1:0] exWord; // word in execute
	logic flush;
	logic [cpuPkg::dataWidth-1:0] regs [cpuPkg::regCount];
	logic [cpuPkg::dataWidth-1:0] memory [cpuPkg::memDepth];
	logic zeroFlag;
	logic carryFlag;
	logic [cpuPkg::pcWidth-1:0] stack [cpuPkg::stackDepth];
	logic [cpuPkg::stackPtrWidth-1:0] stackPtr;

	// predictions for the current cycle, filled in by evaluate
	logic expRegWrite;
	logic [cpuPkg::regAddrWidth-1:0] expRegAddr;
	logic [cpuPkg::dataWidth-1:0] expRegData;
	logic expMemWrite;
	logic [cpuPkg::memAddrWidth-1:0] expMemAddr;
	logic [cpuPkg::dataWidth-1:0] expMemData;
	logic zeroEnable;
	logic zeroValue;
	logic carryEnable;
	logic carryValue;
	logic pushNow;
	logic popNow;
	logic stallNow;
	logic [cpuPkg::pcWidth-1:0] nextPc;

	task automatic resetState();
		for (int i = 0; i < cpuPkg::regCount; i++)
			regs[i] = '0;
		for (int i = 0; i < cpuPkg::memDepth; i++)
			memory[i] = '0;
		for (int i = 0; i < cpuPkg::stackDepth; i++)
			stack[i] = '0; // the bench program fills every entry before any return
		fetchPc = '0;
		exPc = '0;
		exWord = cpuPkg::nopWord;
		flush = 1'b1; // the first word after reset is thrown away
		zeroFlag = 1'b0;
		carryFlag = 1'b0;
		stackPtr = '0;
	endtask

	// decode the executing word straight from the opcode bits
	task automatic evaluate();
		logic [cpuPkg::instrWidth-1:0] w;
		logic [cpuPkg::stackPtrWidth-1:0] topEntry;
		logic taken;
		int a;
		int b;
		int r;
		int n;
		int imm;
		int address;
		w = exWord;
		a = int'(regs[w[10:8]]); // rs1
		imm = int'(w[7:0]);
		n = int'(w[7:5]); // shift amount
		topEntry = stackPtr - 1'b1;
		expRegWrite = 1'b0;
		expRegAddr = w[13:11];
		expRegData = '0;
		expMemWrite = 1'b0;
		expMemAddr = '0;
		expMemData = '0;
		zeroEnable = 1'b0;
		carryEnable = 1'b0;
		zeroValue = 1'b0;
		carryValue = 1'b0;
		pushNow = 1'b0;
		popNow = 1'b0;
		stallNow = 1'b0;
		taken = 1'b0;
		nextPc = fetchPc + 1'b1;
		if (flush) begin
			// squashed word, nothing happens
		end else if (w[18] == 1'b0) begin
			b = w[17] ? imm : int'(regs[w[7:5]]); // immediate form when bit 17 is set
			case (w[16:14])
				3'd0: r = a + b;
				3'd1: r = a + b + int'(carryFlag);
				3'd2: r = a - b;
				3'd3: r = a - b - (carryFlag ? 0 : 1); // clear carry means a borrow is pending
				3'd4: r = a & b;
				3'd5: r = a | b;
				3'd6: r = a ^ b;
				default: r = a & (255 - b);
			endcase
			// adds carry out past 255, subtracts carry when nothing was borrowed
			carryValue = w[16] ? 1'b0 : (w[15] ? (r >= 0) : (r > 255));
			expRegData = cpuPkg::dataWidth'(r);
			zeroValue = (expRegData == '0);
			expRegWrite = 1'b1;
			zeroEnable = 1'b1;
			carryEnable = 1'b1;
		end else if (w[18:16] == 3'b110) begin
			case (w[15:14])
				2'd0: r = a << n;
				2'd1: r = a >> n;
				2'd2: r = (a << n) | (a >> (8 - n));
				default: r = (a >> n) | (a << (8 - n));
			endcase
			if (w[14] == 1'b0)
				carryValue = ((a << n) >> 8) & 1; // bit that left through the top
			else if (n != 0)
				carryValue = (a >> (n - 1)) & 1; // bit that left through the bottom
			expRegData = cpuPkg::dataWidth'(r);
			expRegWrite = 1'b1;
			carryEnable = 1'b1;
		end else if (w[18:16] == 3'b100) begin
			address = (a + imm) & 255;
			if (w[15:14] == 2'b00) begin
				expRegWrite = 1'b1;
				expRegData = memory[address];
			end else if (w[15:14] == 2'b01) begin
				expMemWrite = 1'b1;
				expMemAddr = cpuPkg::memAddrWidth'(address);
				expMemData = regs[w[13:11]]; // rd holds the byte to store
			end
		end else if (w[18:16] == 3'b101) begin
			case (w[15:14])
				2'd0: taken = zeroFlag;
				2'd1: taken = !zeroFlag;
				2'd2: taken = carryFlag;
				default: taken = !carryFlag;
			endcase
			if (taken) begin
				stallNow = 1'b1;
				nextPc = cpuPkg::pcWidth'(int'(exPc) + (imm >= 128 ? imm - 256 : imm));
			end
		end else if (w[18:15] == 4'b1110) begin
			stallNow = 1'b1;
			pushNow = w[14]; // call when bit 14 is set, plain jump otherwise
			nextPc = w[11:0];
		end else if (w[18:13] == 6'b111100) begin
			stallNow = 1'b1;
			popNow = 1'b1;
			nextPc = stack[topEntry];
		end
	endtask

	// apply the cycle's effects at the clock edge, fetched is the word arriving next cycle
	task automatic commit(input logic [cpuPkg::instrWidth-1:0] fetched);
		if (expRegWrite)
			regs[expRegAddr] = expRegData;
		if (expMemWrite)
			memory[expMemAddr] = expMemData;
		if (zeroEnable)
			zeroFlag = zeroValue;
		if (carryEnable)
			carryFlag = carryValue;
		if (pushNow) begin
			stack[stackPtr] = exPc + 1'b1;
			stackPtr = stackPtr + 1'b1; // wraps over the oldest entry
		end else if (popNow) begin
			stackPtr = stackPtr - 1'b1;
		end
		exWord = fetched;
		exPc = fetchPc;
		flush = stallNow;
		fetchPc = nextPc;
	endtask

endmodule

`default_nettype wire

/* hw/processor.sv */
`default_nettype none

module processor (
	input logic clock,
	input logic rst,
	input logic [cpuPkg::instrWidth-1:0] instruction,
	output logic [cpuPkg::pcWidth-1:0] pc,
	output logic regWrite,
	output logic [cpuPkg::regAddrWidth-1:0] regAddr,
	output logic [cpuPkg::dataWidth-1:0] regData,
	output logic memWrite,
	output logic [cpuPkg::memAddrWidth-1:0] memAddr,
	output logic [cpuPkg::dataWidth-1:0] memData
);

	logic stall;
	logic selectR2;
	logic aluInputBSel;
	logic regWriteEnable;
	logic memWriteEnable;
	logic enableZero;
	logic enableCarry;
	logic push;
	logic pop;
	logic pcAdderInputASel;
	logic regFileWriteDataSel;
	logic zero;
	logic carryOut;
	cpuPkg::pcSource pcInputSel;
	cpuPkg::aluOp aluFunction;

	logic [cpuPkg::regAddrWidth-1:0] rd;
	logic [cpuPkg::regAddrWidth-1:0] rs1;
	logic [cpuPkg::regAddrWidth-1:0] rs2;
	logic [cpuPkg::regAddrWidth-1:0] readAddr2; // rs2 for ALU ops, rd for stores
	logic [cpuPkg::dataWidth-1:0] readData1;
	logic [cpuPkg::dataWidth-1:0] readData2;
	logic [cpuPkg::dataWidth-1:0] immediate;
	logic [cpuPkg::dataWidth-1:0] aluB;
	logic [cpuPkg::dataWidth-1:0] aluResult;
	logic [cpuPkg::dataWidth-1:0] memReadData;
	logic [cpuPkg::dataWidth-1:0] writeData;

	assign rd = instruction[cpuPkg::rdHi:cpuPkg::rdLo];
	assign rs1 = instruction[cpuPkg::rs1Hi:cpuPkg::rs1Lo];
	assign rs2 = instruction[cpuPkg::rs2Hi:cpuPkg::rs2Lo];
	assign immediate = instruction[cpuPkg::immHi:cpuPkg::immLo];

	assign readAddr2 = selectR2 ? rd : rs2;
	assign aluB = aluInputBSel ? immediate : readData2;
	assign writeData = regFileWriteDataSel ? aluResult : memReadData;

	// write ports are visible outside for checking
	assign regWrite = regWriteEnable;
	assign regAddr = rd;
	assign regData = writeData;
	assign memWrite = memWriteEnable;
	assign memAddr = aluResult; // rs1 plus imm for loads and stores
	assign memData = readData2;

	controller ctrl (
		.clock(clock),
		.rst(rst),
		.instruction(instruction),
		.zero(zero),
		.carryOut(carryOut),
		.stall(stall),
		.selectR2(selectR2),
		.aluInputBSel(aluInputBSel),
		.regWriteEnable(regWriteEnable),
		.memWriteEnable(memWriteEnable),
		.enableZero(enableZero),
		.enableCarry(enableCarry),
		.push(push),
		.pop(pop),
		.pcInputSel(pcInputSel),
		.pcAdderInputASel(pcAdderInputASel),
		.regFileWriteDataSel(regFileWriteDataSel),
		.aluFunction(aluFunction)
	);

	alu aluUnit (
		.clock(clock),
		.rst(rst),
		.a(readData1),
		.b(aluB),
		.aluFunction(aluFunction),
		.enableZero(enableZero),
		.enableCarry(enableCarry),
		.shiftAmount(instruction[cpuPkg::shiftHi:cpuPkg::shiftLo]),
		.result(aluResult),
		.zero(zero),
		.carryOut(carryOut)
	);

	registerFile regFile (
		.clock(clock),
		.rst(rst),
		.readAddr1(rs1),
		.readAddr2(readAddr2),
		.writeEnable(regWriteEnable),
		.writeAddr(rd),
		.writeData(writeData),
		.readData1(readData1),
		.readData2(readData2)
	);

	programCounter pcUnit (
		.clock(clock),
		.rst(rst),
		.pcInputSel(pcInputSel),
		.pcAdderInputASel(pcAdderInputASel),
		.push(push),
		.pop(pop),
		.stall(stall),
		.offset(immediate), // branch offset shares the imm field
		.jumpAddress(instruction[cpuPkg::jumpHi:cpuPkg::jumpLo]),
		.pc(pc)
	);

	dataMemory dataMem (
		.clock(clock),
		.rst(rst),
		.writeEnable(memWriteEnable),
		.address(aluResult),
		.writeData(readData2),
		.readData(memReadData)
	);

endmodule

`default_nettype wire

/* hw/dataMemory.sv */
`default_nettype none

module dataMemory (
	input logic clock,
	input logic rst,
	input logic writeEnable,
	input logic [cpuPkg::memAddrWidth-1:0] address,
	input logic [cpuPkg::dataWidth-1:0] writeData,
	output logic [cpuPkg::dataWidth-1:0] readData
);

	logic [cpuPkg::dataWidth-1:0] mem [cpuPkg::memDepth];

	// a load in the same cycle as reset release reads zero
	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < cpuPkg::memDepth; i++) begin
				mem[i] <= '0;
			end
		end else if (writeEnable) begin
			mem[address] <= writeData;
		end
	end

	assign readData = mem[address]; // load completes in the execute cycle

endmodule

`default_nettype wire

/* hw/programCounter.sv */
`default_nettype none

module programCounter (
	input logic clock,
	input logic rst,
	input cpuPkg::pcSource pcInputSel,
	input logic pcAdderInputASel,
	input logic push,
	input logic pop,
	input logic stall,
	input logic [cpuPkg::immWidth-1:0] offset,
	input logic [cpuPkg::pcWidth-1:0] jumpAddress,
	output logic [cpuPkg::pcWidth-1:0] pc
);

	logic [cpuPkg::pcWidth-1:0] exPc; // address of the word now executing
	logic [cpuPkg::pcWidth-1:0] stack [cpuPkg::stackDepth];
	logic [cpuPkg::stackPtrWidth-1:0] stackPtr; // next free entry
	logic [cpuPkg::stackPtrWidth-1:0] topPtr;
	logic [cpuPkg::pcWidth-1:0] adderA;
	logic [cpuPkg::pcWidth-1:0] adderB;
	logic [cpuPkg::pcWidth-1:0] adderSum;
	logic [cpuPkg::pcWidth-1:0] returnAddr;
	logic [cpuPkg::pcWidth-1:0] nextPc;

	assign topPtr = stackPtr - 1'b1; // wraps from 0 to the last entry
	assign returnAddr = stack[topPtr];

	// one adder serves both sequential fetch and branch targets
	assign adderA = pcAdderInputASel ? pc : exPc;
	assign adderB = pcAdderInputASel ? cpuPkg::pcWidth'(1)
		: {{(cpuPkg::pcWidth - cpuPkg::immWidth){offset[cpuPkg::immWidth-1]}}, offset};
	assign adderSum = adderA + adderB;

	always_comb begin
		case (pcInputSel)
			cpuPkg::pcJump: nextPc = jumpAddress;
			cpuPkg::pcReturn: nextPc = returnAddr;
			default: nextPc = adderSum;
		endcase
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			pc <= '0;
			exPc <= '0;
			stackPtr <= '0;
		end else begin
			pc <= nextPc; // no hold, fetch moves every cycle
			exPc <= pc;
			if (push)
				stackPtr <= stackPtr + 1'b1; // overflow overwrites the oldest entry
			else if (pop)
				stackPtr <= topPtr;
		end
	end

	// return stack, written only by calls
	always_ff @(posedge clock) begin
		if (push)
			stack[stackPtr] <= exPc + 1'b1; // return lands just past the call
	end

	// every redirect of the fetch must squash the word already in flight
	redirectStalls: assert property (@(posedge clock) disable iff (rst)
		(pcInputSel != cpuPkg::pcAdder || !pcAdderInputASel) |-> stall);

endmodule

`default_nettype wire

/* hw/registerFile.sv */
`default_nettype none

module registerFile (
	input logic clock,
	input logic rst,
	input logic [cpuPkg::regAddrWidth-1:0] readAddr1,
	input logic [cpuPkg::regAddrWidth-1:0] readAddr2,
	input logic writeEnable,
	input logic [cpuPkg::regAddrWidth-1:0] writeAddr,
	input logic [cpuPkg::dataWidth-1:0] writeData,
	output logic [cpuPkg::dataWidth-1:0] readData1,
	output logic [cpuPkg::dataWidth-1:0] readData2
);

	logic [cpuPkg::dataWidth-1:0] regs [cpuPkg::regCount]; // r0 is an ordinary register

	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < cpuPkg::regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEnable) begin
			regs[writeAddr] <= writeData;
		end
	end

	// reads see the old value during a write to the same register
	assign readData1 = regs[readAddr1];
	assign readData2 = regs[readAddr2];

endmodule

`default_nettype wire

/* hw/alu.sv */
`default_nettype none

module alu (
	input logic clock,
	input logic rst,
	input logic [cpuPkg::dataWidth-1:0] a,
	input logic [cpuPkg::dataWidth-1:0] b,
	input cpuPkg::aluOp aluFunction,
	input logic enableZero,
	input logic enableCarry,
	input logic [cpuPkg::shiftWidth-1:0] shiftAmount,
	output logic [cpuPkg::dataWidth-1:0] result,
	output logic zero,
	output logic carryOut
);

	logic carryNext; // carry of this operation, stored only when enabled

	always_comb begin
		int n;
		n = int'(shiftAmount);
		result = '0;
		carryNext = 1'b0; // logic ops clear carry
		case (aluFunction)
			cpuPkg::add: {carryNext, result} = {1'b0, a} + {1'b0, b};
			cpuPkg::addCarry: {carryNext, result} = {1'b0, a} + {1'b0, b} + carryOut;
			// carry set means no borrow, so subtraction adds the complement
			cpuPkg::sub: {carryNext, result} = {1'b0, a} + {1'b0, ~b} + 1'b1;
			cpuPkg::subBorrow: {carryNext, result} = {1'b0, a} + {1'b0, ~b} + carryOut;
			cpuPkg::andOp: result = a & b;
			cpuPkg::orOp: result = a | b;
			cpuPkg::xorOp: result = a ^ b;
			cpuPkg::andNot: result = a & ~b;
			cpuPkg::shiftLeft: begin
				result = a << n;
				carryNext = (n == 0) ? 1'b0 : a[cpuPkg::dataWidth - n]; // last bit out the top
			end
			cpuPkg::shiftRight: begin
				result = a >> n;
				carryNext = (n == 0) ? 1'b0 : a[n - 1];
			end
			cpuPkg::rotateLeft: begin
				result = (a << n) | (a >> (cpuPkg::dataWidth - n));
				carryNext = (n == 0) ? 1'b0 : a[cpuPkg::dataWidth - n];
			end
			cpuPkg::rotateRight: begin
				result = (a >> n) | (a << (cpuPkg::dataWidth - n));
				carryNext = (n == 0) ? 1'b0 : a[n - 1]; // bit that wrapped to the top
			end
			default: ;
		endcase
	end

	// flags are the only state in here, each with its own enable
	always_ff @(posedge clock) begin
		if (rst) begin
			zero <= 1'b0;
			carryOut <= 1'b0;
		end else begin
			if (enableZero)
				zero <= (result == '0);
			if (enableCarry)
				carryOut <= carryNext;
		end
	end

	// decode must never let a shift touch the zero flag
	zeroNotOnShift: assert property (@(posedge clock) disable iff (rst)
		enableZero |-> !(aluFunction inside {cpuPkg::shiftLeft, cpuPkg::shiftRight,
			cpuPkg::rotateLeft, cpuPkg::rotateRight}));

endmodule

`default_nettype wire

/* hw/controller.sv */
`default_nettype none

module controller (
	input logic clock,
	input logic rst,
	input logic [cpuPkg::instrWidth-1:0] instruction,
	input logic zero,
	input logic carryOut,
	output logic stall,
	output logic selectR2,
	output logic aluInputBSel,
	output logic regWriteEnable,
	output logic memWriteEnable,
	output logic enableZero,
	output logic enableCarry,
	output logic push,
	output logic pop,
	output cpuPkg::pcSource pcInputSel,
	output logic pcAdderInputASel,
	output logic regFileWriteDataSel,
	output cpuPkg::aluOp aluFunction
);

	logic flush; // the fetched word behind a taken transfer is not executed
	logic branchTaken;
	logic [cpuPkg::instrWidth-1:0] word;
	logic [cpuPkg::opHi-cpuPkg::opLo:0] opcode;
	logic [cpuPkg::fnHi-cpuPkg::fnLo:0] fn3;
	logic [cpuPkg::fnHi-cpuPkg::fnLo-1:0] fn2;

	assign word = flush ? cpuPkg::nopWord : instruction; // a flushed word decodes as nop
	assign opcode = word[cpuPkg::opHi:cpuPkg::opLo];
	assign fn3 = word[cpuPkg::fnHi:cpuPkg::fnLo];
	assign fn2 = word[cpuPkg::fnHi-1:cpuPkg::fnLo]; // shift kind, memory op or branch condition

	// reset also flushes so the first word after reset does nothing
	always_ff @(posedge clock) begin
		if (rst)
			flush <= 1'b1;
		else
			flush <= stall;
	end

	always_comb begin
		stall = 1'b0;
		selectR2 = 1'b0; // rs2 on the second read port
		aluInputBSel = 1'b0; // register operand
		regWriteEnable = 1'b0;
		memWriteEnable = 1'b0;
		enableZero = 1'b0;
		enableCarry = 1'b0;
		push = 1'b0;
		pop = 1'b0;
		pcInputSel = cpuPkg::pcAdder;
		pcAdderInputASel = 1'b1; // adder counts the fetch pc up by one
		regFileWriteDataSel = 1'b1; // ALU result goes back to rd
		aluFunction = cpuPkg::add;
		branchTaken = 1'b0;

		casez (opcode)
			6'b00????: begin // register ALU op
				aluFunction = cpuPkg::aluOp'({1'b1, fn3});
				regWriteEnable = 1'b1;
				enableZero = 1'b1;
				enableCarry = 1'b1;
			end
			6'b01????: begin // immediate ALU op
				aluFunction = cpuPkg::aluOp'({1'b1, fn3});
				aluInputBSel = 1'b1;
				regWriteEnable = 1'b1;
				enableZero = 1'b1;
				enableCarry = 1'b1;
			end
			6'b110???: begin
				aluFunction = cpuPkg::aluOp'({2'b00, fn2}); // shifts leave zero untouched
				regWriteEnable = 1'b1;
				enableCarry = 1'b1;
			end
			6'b100???: begin
				aluInputBSel = 1'b1; // address is rs1 plus imm
				if (fn2 == 2'b00) begin
					regWriteEnable = 1'b1;
					regFileWriteDataSel = 1'b0; // load data comes from memory
				end else if (fn2 == 2'b01) begin
					memWriteEnable = 1'b1;
					selectR2 = 1'b1; // rd supplies the store data
				end
			end
			6'b101???: begin
				case (fn2)
					2'b00: branchTaken = zero;
					2'b01: branchTaken = !zero;
					2'b10: branchTaken = carryOut;
					default: branchTaken = !carryOut;
				endcase
				if (branchTaken) begin
					pcAdderInputASel = 1'b0; // adder takes execute pc plus offset
					stall = 1'b1;
				end
			end
			6'b11100?: begin
				pcInputSel = cpuPkg::pcJump;
				stall = 1'b1;
			end
			6'b11101?: begin // call pushes the return address as it jumps
				pcInputSel = cpuPkg::pcJump;
				push = 1'b1;
				stall = 1'b1;
			end
			6'b111100: begin
				pcInputSel = cpuPkg::pcReturn;
				pop = 1'b1;
				stall = 1'b1;
			end
			default: ; // unused codes fall through as nop
		endcase

		if (flush) begin // the nop word would still write r0 and the flags
			regWriteEnable = 1'b0;
			enableZero = 1'b0;
			enableCarry = 1'b0;
		end
	end

	// only one way of moving the pc per cycle
	pcControlOneHot: assert property (@(posedge clock) disable iff (rst)
		$onehot0({push, pop, branchTaken}));

	writeExclusive: assert property (@(posedge clock) disable iff (rst)
		!(memWriteEnable && regWriteEnable));

	// the squashed word must leave no trace
	quietAfterStall: assert property (@(posedge clock) disable iff (rst)
		stall |=> !(regWriteEnable || memWriteEnable || enableZero || enableCarry
			|| push || pop || stall));

endmodule

`default_nettype wire

/* hw/cpuPkg.sv */
`default_nettype none

package cpuPkg;

	localparam int dataWidth = 8; // registers, ALU and data memory all share this width
	localparam int instrWidth = 19;
	localparam int pcWidth = 12; // 4k words of instruction space
	localparam int regCount = 8;
	localparam int regAddrWidth = $clog2(regCount);
	localparam int stackDepth = 8; // return stack entries
	localparam int stackPtrWidth = $clog2(stackDepth); // pointer wraps by overflowing
	localparam int memDepth = 256;
	localparam int memAddrWidth = $clog2(memDepth); // the ALU result is used as is

	// instruction fields
	localparam int opHi = 18; // six prefix bits cover every opcode length
	localparam int opLo = 13;
	localparam int fnHi = 16; // three-bit ALU function, the low two serve as short function
	localparam int fnLo = 14;
	localparam int rdHi = 13;
	localparam int rdLo = 11;
	localparam int rs1Hi = 10;
	localparam int rs1Lo = 8;
	localparam int rs2Hi = 7;
	localparam int rs2Lo = 5;
	localparam int shiftHi = 7;
	localparam int shiftLo = 5;
	localparam int shiftWidth = shiftHi - shiftLo + 1;
	localparam int immHi = 7; // also the branch offset
	localparam int immLo = 0;
	localparam int immWidth = immHi - immLo + 1;
	localparam int jumpHi = 11;
	localparam int jumpLo = 0;

	// top bit set picks the arithmetic and logic group, 00 the shift group
	typedef enum logic [3:0] {
		shiftLeft = 4'b0000,
		shiftRight = 4'b0001,
		rotateLeft = 4'b0010,
		rotateRight = 4'b0011,
		add = 4'b1000,
		addCarry = 4'b1001,
		sub = 4'b1010,
		subBorrow = 4'b1011,
		andOp = 4'b1100,
		orOp = 4'b1101,
		xorOp = 4'b1110,
		andNot = 4'b1111
	} aluOp;

	typedef enum logic [1:0] {
		pcAdder = 2'b00, // pc+1 or a branch target, whatever the adder produces
		pcJump = 2'b01,
		pcReturn = 2'b10
	} pcSource;

	localparam logic [instrWidth-1:0] nopWord = '0; // add r0,r0,r0 once its strobes are masked

endpackage

`default_nettype wire
